/* common/rv_decode_pkg.sv */
package rv_decode_pkg;

    // ************************************************************
    // widths
    // ************************************************************
    localparam int xlen        = 32;     // data and instruction width.
    localparam int reg_count   = 32;     // architectural registers.
    localparam int reg_index_w = 5;
    localparam int opcode_w    = 7;
    localparam int funct3_w    = 3;
    localparam int funct7_w    = 7;

    // field positions, identical for every format.
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    // ************************************************************
    // base opcodes, matched against instruction[6:2]
    // ************************************************************
    localparam logic [4:0] opc_load     = 5'b00000;
    localparam logic [4:0] opc_misc_mem = 5'b00011;  // fence.
    localparam logic [4:0] opc_op_imm   = 5'b00100;
    localparam logic [4:0] opc_auipc    = 5'b00101;
    localparam logic [4:0] opc_store    = 5'b01000;
    localparam logic [4:0] opc_op       = 5'b01100;
    localparam logic [4:0] opc_lui      = 5'b01101;
    localparam logic [4:0] opc_op_fp    = 5'b10100;
    localparam logic [4:0] opc_branch   = 5'b11000;
    localparam logic [4:0] opc_jalr     = 5'b11001;
    localparam logic [4:0] opc_jal      = 5'b11011;

    localparam logic [1:0] opc_quadrant = 2'b11;     // 32-bit encodings only.

    // instruction formats.
    typedef enum logic [2:0] {
        type_i       = 3'd0,
        type_b       = 3'd1,
        type_s       = 3'd2,
        type_u       = 3'd3,
        type_j       = 3'd4,
        type_r       = 3'd5,
        type_illegal = 3'd6
    } instr_type_t;

    // ************************************************************
    // stage payloads
    // ************************************************************
    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        logic                   branch;
        instr_type_t            itype;
        logic [opcode_w-1:0]    opcode;
        logic [funct3_w-1:0]    funct3;
        logic [funct7_w-1:0]    funct7;
        logic [reg_index_w-1:0] rs1;
        logic [reg_index_w-1:0] rs2;
        logic [reg_index_w-1:0] rd;
        logic [xlen-1:0]        imm;
        logic [xlen-1:0]        rs1_data;
        logic [xlen-1:0]        rs2_data;
    } decoded_t;

    typedef struct packed {
        logic                   we;     // write enable from writeback.
        logic [reg_index_w-1:0] rd;
        logic [xlen-1:0]        data;
    } wb_t;

endpackage

/* decoder/instruction_decoder.sv */
`timescale 1ns/1ps

module instruction_decoder (
    input  logic [rv_decode_pkg::xlen-1:0]        instruction,
    output rv_decode_pkg::instr_type_t            itype,
    output logic                                  illegal,
    output logic                                  branch,
    output logic [rv_decode_pkg::opcode_w-1:0]    opcode,
    output logic [rv_decode_pkg::funct3_w-1:0]    funct3,
    output logic [rv_decode_pkg::funct7_w-1:0]    funct7,
    output logic [rv_decode_pkg::reg_index_w-1:0] rs1,
    output logic [rv_decode_pkg::reg_index_w-1:0] rs2,
    output logic [rv_decode_pkg::reg_index_w-1:0] rd
);

    logic [4:0] major;      // opcode without the quadrant bits.
    logic [1:0] quadrant;

    assign major    = instruction[6:2];
    assign quadrant = instruction[1:0];

    // ************************************************************
    // format classification
    // ************************************************************
    always_comb begin
        if (quadrant != rv_decode_pkg::opc_quadrant) begin
            itype = rv_decode_pkg::type_illegal;    // compressed or reserved.
        end else begin
            case (major)
                rv_decode_pkg::opc_load,
                rv_decode_pkg::opc_op_imm,
                rv_decode_pkg::opc_jalr,
                rv_decode_pkg::opc_misc_mem: itype = rv_decode_pkg::type_i;
                rv_decode_pkg::opc_branch:   itype = rv_decode_pkg::type_b;
                rv_decode_pkg::opc_store:    itype = rv_decode_pkg::type_s;
                rv_decode_pkg::opc_lui,
                rv_decode_pkg::opc_auipc:    itype = rv_decode_pkg::type_u;
                rv_decode_pkg::opc_jal:      itype = rv_decode_pkg::type_j;
                rv_decode_pkg::opc_op,
                rv_decode_pkg::opc_op_fp:    itype = rv_decode_pkg::type_r;
                default:                     itype = rv_decode_pkg::type_illegal;
            endcase
        end
    end

    assign illegal = (itype == rv_decode_pkg::type_illegal);
    assign branch  = (itype == rv_decode_pkg::type_b);      // conditional branches only.

    // ************************************************************
    // fixed field slices
    // ************************************************************
    assign opcode = instruction[rv_decode_pkg::opcode_w-1:0];
    assign funct3 = instruction[rv_decode_pkg::funct3_lsb +: rv_decode_pkg::funct3_w];
    assign funct7 = instruction[rv_decode_pkg::funct7_lsb +: rv_decode_pkg::funct7_w];

    // register indices are sliced even when the format has no such field.
    assign rs1 = instruction[rv_decode_pkg::rs1_lsb +: rv_decode_pkg::reg_index_w];
    assign rs2 = instruction[rv_decode_pkg::rs2_lsb +: rv_decode_pkg::reg_index_w];
    assign rd  = instruction[rv_decode_pkg::rd_lsb +: rv_decode_pkg::reg_index_w];

endmodule

/* decoder/immediate_generator.sv */
`timescale 1ns/1ps

module immediate_generator (
    input  logic [rv_decode_pkg::xlen-1:0] instruction,
    input  rv_decode_pkg::instr_type_t     itype,
    output logic [rv_decode_pkg::xlen-1:0] imm
);

    logic sign;     // every format takes its sign from bit 31.

    assign sign = instruction[31];

    // ************************************************************
    // immediate assembly per format
    // ************************************************************
    always_comb begin
        case (itype)
            rv_decode_pkg::type_i: begin
                imm = {{20{sign}}, instruction[31:20]};
            end
            rv_decode_pkg::type_s: begin
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            rv_decode_pkg::type_b: begin
                // branch offsets are in half-words.
                imm = {{19{sign}},
                       instruction[31],
                       instruction[7],
                       instruction[30:25],
                       instruction[11:8],
                       1'b0};
            end
            rv_decode_pkg::type_u: begin
                imm = {instruction[31:12], 12'b0};     // upper 20 bits, already signed.
            end
            rv_decode_pkg::type_j: begin
                imm = {{11{sign}},
                       instruction[31],
                       instruction[19:12],
                       instruction[20],
                       instruction[30:21],
                       1'b0};
            end
            default: begin
                imm = '0;       // r-format and illegal carry no immediate.
            end
        endcase
    end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [rv_decode_pkg::reg_index_w-1:0] rs1,
    input  logic [rv_decode_pkg::reg_index_w-1:0] rs2,
    output logic [rv_decode_pkg::xlen-1:0]        rs1_data,
    output logic [rv_decode_pkg::xlen-1:0]        rs2_data,
    input  rv_decode_pkg::wb_t                    wb
);

    logic [rv_decode_pkg::xlen-1:0] regs [rv_decode_pkg::reg_count];

    // ************************************************************
    // write port
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rv_decode_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;     // x0 is never written.
        end
    end

    // one read port: x0 rule, then bypass, then the array.
    function automatic logic [rv_decode_pkg::xlen-1:0] read_port(
        input logic [rv_decode_pkg::reg_index_w-1:0] idx
    );
        logic [rv_decode_pkg::xlen-1:0] value;
        if (idx == '0) begin
            value = '0;
        end else if (wb.we && wb.rd == idx) begin
            value = wb.data;        // same-cycle writeback.
        end else begin
            value = regs[idx];
        end
        return value;
    endfunction

    always_comb rs1_data = read_port(rs1);
    always_comb rs2_data = read_port(rs2);

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           in_valid,
    input  logic [rv_decode_pkg::xlen-1:0] instruction,
    input  logic                           stall,
    input  rv_decode_pkg::wb_t             wb,
    output rv_decode_pkg::decoded_t        id_ex
);

    rv_decode_pkg::instr_type_t            itype;
    logic                                  illegal;
    logic                                  branch;
    logic [rv_decode_pkg::opcode_w-1:0]    opcode;
    logic [rv_decode_pkg::funct3_w-1:0]    funct3;
    logic [rv_decode_pkg::funct7_w-1:0]    funct7;
    logic [rv_decode_pkg::reg_index_w-1:0] rs1;
    logic [rv_decode_pkg::reg_index_w-1:0] rs2;
    logic [rv_decode_pkg::reg_index_w-1:0] rd;
    logic [rv_decode_pkg::xlen-1:0]        imm;
    logic [rv_decode_pkg::xlen-1:0]        rs1_data;
    logic [rv_decode_pkg::xlen-1:0]        rs2_data;
    rv_decode_pkg::decoded_t               decoded;

    // ************************************************************
    // combinational decode
    // ************************************************************
    instruction_decoder decoder0 (
        .instruction (instruction),
        .itype       (itype),
        .illegal     (illegal),
        .branch      (branch),
        .opcode      (opcode),
        .funct3      (funct3),
        .funct7      (funct7),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd)
    );

    immediate_generator immgen0 (
        .instruction (instruction),
        .itype       (itype),
        .imm         (imm)
    );

    register_file regfile0 (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb)
    );

    always_comb begin
        decoded.valid    = in_valid;
        decoded.illegal  = illegal;
        decoded.branch   = branch;
        decoded.itype    = itype;
        decoded.opcode   = opcode;
        decoded.funct3   = funct3;
        decoded.funct7   = funct7;
        decoded.rs1      = rs1;
        decoded.rs2      = rs2;
        decoded.rd       = rd;
        decoded.imm      = imm;
        decoded.rs1_data = rs1_data;   // includes writeback bypass.
        decoded.rs2_data = rs2_data;
    end

    // ************************************************************
    // decode/execute register
    // ************************************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else if (!stall) begin
            id_ex <= decoded;       // stall holds the whole struct.
        end
    end

endmodule

/* tests/decode_stage_assert.sv */
`timescale 1ns/1ps

module decode_stage_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    in_valid,
    input logic                    stall,
    input rv_decode_pkg::decoded_t id_ex
);

    // ************************************************************
    // decode/execute register rules
    // ************************************************************
    valid_follows_input: assert property (@(posedge clk) disable iff (rst)
        (!in_valid && !stall) |=> !id_ex.valid)
        else $error("id_ex.valid set without a sampled instruction");

    stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(id_ex))
        else $error("id_ex changed while stalled");

    illegal_type: assert property (@(posedge clk) disable iff (rst)
        (id_ex.valid && id_ex.opcode[1:0] != rv_decode_pkg::opc_quadrant) |->
            (id_ex.illegal && id_ex.itype == rv_decode_pkg::type_illegal))
        else $error("non 32-bit encoding not flagged as illegal");

    x0_zero: assert property (@(posedge clk) disable iff (rst)
        (id_ex.valid && id_ex.rs1 == '0) |-> id_ex.rs1_data == '0)
        else $error("x0 read returned nonzero data");

endmodule

bind decode_stage decode_stage_assert assert0 (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .stall    (stall),
    .id_ex    (id_ex)
);

/* tests/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb;

    localparam int wait_limit = 20;     // cycles before a wait gives up.

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic [31:0]             instruction;
    logic                    stall;
    rv_decode_pkg::wb_t      wb;
    rv_decode_pkg::decoded_t id_ex;

    logic [31:0] lfsr;
    logic [31:0] model_regs [32];      // expected register contents.
    string       test_name;
    int          checks;
    int          errors;
    int          test_errors;

    // base opcodes of the legal classes, then some that must decode as illegal.
    logic [6:0] legal_opcodes [11] = '{7'h03, 7'h13, 7'h67, 7'h0f, 7'h63, 7'h23,
                                       7'h37, 7'h17, 7'h6f, 7'h33, 7'h53};
    logic [6:0] illegal_opcodes [5] = '{7'h7f, 7'h07, 7'h73, 7'h11, 7'h12};

    decode_stage dut0 (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .instruction (instruction),
        .stall       (stall),
        .wb          (wb),
        .id_ex       (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ************************************************************
    // stimulus source and reference model
    // ************************************************************
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];    // taps 32, 22, 2, 1.
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic rv_decode_pkg::instr_type_t model_type(input logic [31:0] instr);
        case (instr[6:0])
            7'h03, 7'h13, 7'h67, 7'h0f: return rv_decode_pkg::type_i;
            7'h63:                      return rv_decode_pkg::type_b;
            7'h23:                      return rv_decode_pkg::type_s;
            7'h37, 7'h17:               return rv_decode_pkg::type_u;
            7'h6f:                      return rv_decode_pkg::type_j;
            7'h33, 7'h53:               return rv_decode_pkg::type_r;
            default:                    return rv_decode_pkg::type_illegal;
        endcase
    endfunction

    function automatic logic [31:0] model_imm(input logic [31:0] i);
        case (model_type(i))
            rv_decode_pkg::type_i: return {{20{i[31]}}, i[31:20]};
            rv_decode_pkg::type_s: return {{20{i[31]}}, i[31:25], i[11:7]};
            rv_decode_pkg::type_b: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            rv_decode_pkg::type_u: return {i[31:12], 12'b0};
            rv_decode_pkg::type_j: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default:               return '0;
        endcase
    endfunction

    // ************************************************************
    // helpers
    // ************************************************************
    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (expected === actual)
        else begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, field, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("test %-10s done, %0d errors", test_name, test_errors);
    endtask

    // presents one instruction and waits for it to leave the stage.
    task automatic decode(input logic [31:0] instr);
        int cycles;
        instruction = instr;
        in_valid    = 1'b1;
        cycles      = 0;
        do begin
            @(negedge clk);
            in_valid = 1'b0;
            wb.we    = 1'b0;        // writeback lasts one cycle.
            cycles++;
        end while (!id_ex.valid && cycles < wait_limit);
        check_value("latency", 32'd1, 32'(cycles));
        if (!id_ex.valid) begin
            $display("timeout: no valid decode result in test %s", test_name);
            $display("** FAIL **");
            $finish;
        end
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] data);
        wb.we   = 1'b1;
        wb.rd   = rd;
        wb.data = data;
        @(negedge clk);
        wb.we = 1'b0;
        if (rd != 5'd0) begin
            model_regs[rd] = data;
        end
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************
    task automatic reset_test();
        logic [4:0] idx;
        start_test("reset");
        for (int i = 1; i < 32; i++) begin
            write_reg(5'(i), rand_bits(32));    // give reset something to clear.
        end
        decode({7'h00, 5'd1, 5'd1, 3'b000, 5'd1, 7'h33});
        rst = 1'b1;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        check_value("id_ex nonzero", 32'd0, 32'(id_ex != '0));
        for (int i = 0; i < 32; i++) begin
            idx = 5'(i);
            decode({7'h00, idx, idx, 3'b000, 5'd1, 7'h33});
            check_value("rs1_data", 32'd0, id_ex.rs1_data);
            check_value("rs2_data", 32'd0, id_ex.rs2_data);
        end
        finish_test();
    endtask

    task automatic format_check(input logic [6:0] opc);
        logic [31:0]                r;
        logic [31:0]                instr;
        rv_decode_pkg::instr_type_t t;
        r     = rand_bits(25);
        instr = {r[24:0], opc};
        t     = model_type(instr);
        decode(instr);
        check_value("itype", 32'(t), 32'(id_ex.itype));
        check_value("illegal", 32'(t == rv_decode_pkg::type_illegal), 32'(id_ex.illegal));
        check_value("branch", 32'(t == rv_decode_pkg::type_b), 32'(id_ex.branch));
    endtask

    task automatic format_test();
        start_test("formats");
        foreach (legal_opcodes[k]) format_check(legal_opcodes[k]);
        foreach (illegal_opcodes[k]) format_check(illegal_opcodes[k]);
        finish_test();
    endtask

    task automatic immediate_test();
        logic [31:0] r;
        logic [31:0] instr;
        start_test("immediates");
        foreach (legal_opcodes[k]) begin
            for (int n = 0; n < 4; n++) begin
                r     = rand_bits(25);
                instr = {r[24:0], legal_opcodes[k]};
                decode(instr);
                check_value("imm", model_imm(instr), id_ex.imm);
                check_value("opcode", 32'(instr[6:0]), 32'(id_ex.opcode));
                check_value("funct3", 32'(instr[14:12]), 32'(id_ex.funct3));
                check_value("funct7", 32'(instr[31:25]), 32'(id_ex.funct7));
                check_value("rs1", 32'(instr[19:15]), 32'(id_ex.rs1));
                check_value("rs2", 32'(instr[24:20]), 32'(id_ex.rs2));
                check_value("rd", 32'(instr[11:7]), 32'(id_ex.rd));
            end
        end
        finish_test();
    endtask

    task automatic regfile_test();
        logic [31:0] r;
        logic [31:0] d;
        start_test("regfile");
        for (int i = 0; i < 12; i++) begin
            r = rand_bits(5);
            d = rand_bits(32);
            write_reg(i < 2 ? 5'd0 : r[4:0], d);    // first two aim at x0.
        end
        for (int i = 0; i < 12; i++) begin
            r = rand_bits(10);
            decode({7'h00, r[9:5], r[4:0], 3'b000, 5'd2, 7'h33});
            check_value("rs1_data", model_regs[r[4:0]], id_ex.rs1_data);
            check_value("rs2_data", model_regs[r[9:5]], id_ex.rs2_data);
        end
        decode({7'h00, 5'd0, 5'd0, 3'b000, 5'd2, 7'h33});
        check_value("x0 read", 32'd0, id_ex.rs1_data);
        finish_test();
    endtask

    task automatic bypass_test();
        logic [31:0] r;
        logic [31:0] d;
        logic [4:0]  idx;
        start_test("bypass");
        for (int n = 0; n < 4; n++) begin
            r       = rand_bits(5);
            d       = rand_bits(32);
            idx     = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
            wb.we   = 1'b1;
            wb.rd   = idx;
            wb.data = d;
            decode({7'h00, 5'd0, idx, 3'b000, 5'd3, 7'h33});
            model_regs[idx] = d;
            check_value("rs1_data", d, id_ex.rs1_data);
            check_value("rs2_data", 32'd0, id_ex.rs2_data);
            decode({7'h00, 5'd0, idx, 3'b000, 5'd3, 7'h33});    // array now holds it.
            check_value("stored", model_regs[idx], id_ex.rs1_data);
        end
        wb.we   = 1'b1;
        wb.rd   = 5'd0;
        wb.data = rand_bits(32);
        decode({7'h00, 5'd0, 5'd0, 3'b000, 5'd3, 7'h33});
        check_value("x0 bypass", 32'd0, id_ex.rs1_data);
        finish_test();
    endtask

    task automatic stall_test();
        logic [31:0]             r;
        logic [31:0]             instr;
        rv_decode_pkg::decoded_t held;
        start_test("stall");
        r = rand_bits(25);
        decode({r[24:0], 7'h13});
        held  = id_ex;
        stall = 1'b1;
        for (int n = 0; n < 4; n++) begin
            r           = rand_bits(25);
            instruction = {r[24:0], 7'h33};
            in_valid    = 1'b1;
            @(negedge clk);
            check_value("hold", 32'd1, 32'(id_ex == held));
        end
        stall = 1'b0;
        r     = rand_bits(25);
        instr = {r[24:0], 7'h6f};
        decode(instr);
        check_value("imm", model_imm(instr), id_ex.imm);
        check_value("rd", 32'(instr[11:7]), 32'(id_ex.rd));
        finish_test();
    endtask

    // ************************************************************
    // sequence
    // ************************************************************
    initial begin
        lfsr        = 32'h1bfc;
        rst         = 1'b1;
        in_valid    = 1'b0;
        instruction = '0;
        stall       = 1'b0;
        wb          = '0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_test();
        format_test();
        immediate_test();
        regfile_test();
        bypass_test();
        stall_test();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* rv_decode.f */
common/rv_decode_pkg.sv
decoder/instruction_decoder.sv
decoder/immediate_generator.sv
logic/register_file.sv
logic/decode_stage.sv
tests/decode_stage_assert.sv
tests/decode_stage_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module decode_stage_tb -f rv_decode.f

output=$(./obj_dir/Vdecode_stage_tb) || true
echo "$output"

if echo "$output" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1
